/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= cpu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/cpu_dec_if.sv */
`include "cpu_defines.svh"

interface cpu_dec_if import cpu_pkg::*; ();
    alu_op_e             alu_op;
    logic                use_imm;    // Operand b from sign-extended imm
    logic [4:0]          shamt;
    wb_sel_e             sel_wb;
    logic                gp_we;      // ALU result goes to a register
    logic [`CPU_RAW-1:0] wa;
    logic                mem_rd;
    logic                mem_wr;
    logic                branch_eq;
    logic                branch_ne;
    logic                jump;
    logic                spr_wr;     // movg2s
    logic                spr_rd;     // movs2g
    logic                is_eret;
    logic                illegal;

    modport dec (output alu_op, use_imm, shamt, sel_wb, gp_we, wa, mem_rd, mem_wr,
                 branch_eq, branch_ne, jump, spr_wr, spr_rd, is_eret, illegal);
    modport exe (input alu_op, use_imm, shamt, sel_wb, gp_we, branch_eq, branch_ne, jump);
    modport seq (input mem_rd, mem_wr, is_eret, illegal);
endinterface

/* design/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path width
`define CPU_XLEN 32

// Memory port carries word addresses only
`define CPU_AW 30

// General register count and index width
`define CPU_NREG 32
`define CPU_RAW 5

// Byte address of the trap handler
`define CPU_TRAP_VEC 32'h0000_0100

`endif

/* design/cpu_pkg.sv */
package cpu_pkg;

    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        J       = 6'h02,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        ADDI    = 6'h08,
        COP0    = 6'h10,  // movg2s, movs2g, eret
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_SRL = 6'h02,
        FN_ADD = 6'h20, FN_SUB = 6'h22,
        FN_AND = 6'h24, FN_OR  = 6'h25,
        FN_XOR = 6'h26, FN_SLT = 6'h2a
    } funct_e;

    // COP0 operation sits in the rs field
    typedef enum logic [4:0] {
        C0_MOVS2G = 5'h00,
        C0_MOVG2S = 5'h04,
        C0_ERET   = 5'h10
    } cop0_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_SPR, WB_MEM} wb_sel_e;

    typedef enum logic [1:0] {NONE, ILLEGAL, OVERFLOW} cause_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same instruction word, two field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

endpackage

/* design/cpu_sequencer.sv */
`include "cpu_defines.svh"

module cpu_sequencer import cpu_pkg::*; (
    input  logic                 E,
    input  logic                 jisr,
    cpu_dec_if.seq               dec,
    output instr_t               ir,
    input  logic                 branch_taken,
    input  logic [`CPU_XLEN-1:0] target,
    input  logic [`CPU_XLEN-1:0] ea,
    input  logic [`CPU_XLEN-1:0] store_data,
    input  logic                 overflow,
    input  logic [`CPU_XLEN-1:0] epc,
    output logic [`CPU_XLEN-1:0] pc,
    output logic                 commit,
    output logic                 load_done,
    output logic                 trap,
    output cause_e               trap_cause,
    output logic                 mem_req,
    output logic                 mem_we,
    output logic [`CPU_AW-1:0]   mem_addr,
    output logic [`CPU_XLEN-1:0] mem_wdata,
    input  logic [`CPU_XLEN-1:0] mem_rdata,
    input  logic                 mem_rvalid
);
    typedef enum logic [1:0] {FETCH, FWAIT, EXEC, MWAIT} phase_e;

    phase_e               phase;
    logic [`CPU_XLEN-1:0] next_pc;
    logic                 data_acc;

    assign trap       = (phase == EXEC) && (dec.illegal || overflow);
    assign trap_cause = dec.illegal ? ILLEGAL : (overflow ? OVERFLOW : NONE);
    assign commit     = (phase == EXEC) && !trap;
    assign data_acc   = commit && (dec.mem_rd || dec.mem_wr);
    assign load_done  = (phase == MWAIT) && mem_rvalid && dec.mem_rd;

    always_comb begin
        if (trap)
            next_pc = `CPU_TRAP_VEC;
        else if (dec.is_eret)
            next_pc = epc;
        else if (branch_taken)
            next_pc = target;  // Branch or jump
        else
            next_pc = pc + 'd4;
    end

    always_ff @(posedge E or posedge jisr) begin
        if (jisr) begin
            phase   <= FETCH;
            pc      <= '0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            mem_req <= 1'b0;  // Request is a one-cycle pulse
            mem_we  <= 1'b0;
            unique case (phase)
                FETCH: begin
                    mem_req <= 1'b1;
                    phase   <= FWAIT;
                end
                FWAIT: if (mem_rvalid) phase <= EXEC;
                EXEC: begin
                    pc      <= next_pc;
                    mem_req <= 1'b1;  // Data access or next fetch
                    if (data_acc) begin
                        mem_we <= dec.mem_wr;
                        phase  <= MWAIT;
                    end else begin
                        phase  <= FWAIT;
                    end
                end
                MWAIT: if (mem_rvalid) begin
                    mem_req <= 1'b1;  // Fetch at pc already advanced in EXEC
                    phase   <= FWAIT;
                end
            endcase
        end
    end

    // Instruction and request payload
    always_ff @(posedge E) begin
        if (phase == FWAIT && mem_rvalid)
            ir <= mem_rdata;
        if (phase == EXEC) begin
            mem_addr  <= data_acc ? ea[`CPU_XLEN-1:2] : next_pc[`CPU_XLEN-1:2];
            mem_wdata <= store_data;
        end else begin
            mem_addr  <= pc[`CPU_XLEN-1:2];
        end
    end
endmodule

/* design/cpu_top.sv */
`include "cpu_defines.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                 E,
    input  logic                 jisr,
    output logic                 mem_req,
    output logic                 mem_we,
    output logic [`CPU_AW-1:0]   mem_addr,
    output logic [`CPU_XLEN-1:0] mem_wdata,
    input  logic [`CPU_XLEN-1:0] mem_rdata,
    input  logic                 mem_rvalid
);
    instr_t               ir;
    logic [`CPU_XLEN-1:0] pc, epc, spr_rdata;
    logic [`CPU_XLEN-1:0] a, b, result;
    logic [`CPU_XLEN-1:0] target, ea, store_data;
    logic                 overflow, branch_taken;
    logic                 commit, load_done, trap;
    cause_e               trap_cause;
    logic                 gpr_we, spr_we;

    cpu_dec_if dec_bus ();

    // Register writes only on commit, or when load data returns
    assign gpr_we = load_done | (commit & (dec_bus.gp_we | dec_bus.spr_rd));
    assign spr_we = commit & dec_bus.spr_wr;

    cpu_sequencer seq0 (
        .E(E), .jisr(jisr), .dec(dec_bus), .ir(ir),
        .branch_taken(branch_taken), .target(target),
        .ea(ea), .store_data(store_data), .overflow(overflow), .epc(epc),
        .pc(pc), .commit(commit), .load_done(load_done),
        .trap(trap), .trap_cause(trap_cause),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid)
    );

    instr_decoder dec0 (.ir(ir), .dec(dec_bus));

    exec_unit exe0 (
        .dec(dec_bus), .ir(ir), .pc(pc), .a(a), .b(b),
        .spr_rdata(spr_rdata), .mem_rdata(mem_rdata), .load_done(load_done),
        .result(result), .overflow(overflow), .branch_taken(branch_taken),
        .target(target), .ea(ea), .store_data(store_data)
    );

    gpr_file gpr0 (
        .E(E), .jisr(jisr),
        .rs(ir.r_fmt.rs), .rt(ir.r_fmt.rt), .wa(dec_bus.wa),
        .wd(result), .we(gpr_we), .rd1(a), .rd2(b)
    );

    spr_file spr0 (
        .E(E), .jisr(jisr),
        .sel(ir.r_fmt.rd[2:0]), .wdata(b), .wr(spr_we),
        .trap(trap), .trap_cause(trap_cause), .trap_pc(pc),
        .rdata(spr_rdata), .epc(epc)
    );
endmodule

/* design/exec_unit.sv */
`include "cpu_defines.svh"

module exec_unit import cpu_pkg::*; (
    cpu_dec_if.exe               dec,
    input  instr_t               ir,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  logic [`CPU_XLEN-1:0] spr_rdata,
    input  logic [`CPU_XLEN-1:0] mem_rdata,
    input  logic                 load_done,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 overflow,
    output logic                 branch_taken,
    output logic [`CPU_XLEN-1:0] target,
    output logic [`CPU_XLEN-1:0] ea,
    output logic [`CPU_XLEN-1:0] store_data
);
    logic [`CPU_XLEN-1:0] imm_sext, b_op, sum, diff, alu_res, pc_plus4;
    logic                 ovf, eq;

    assign imm_sext = {{(`CPU_XLEN-16){ir.i_fmt.imm[15]}}, ir.i_fmt.imm};
    assign b_op     = dec.use_imm ? imm_sext : b;
    assign sum      = a + b_op;
    assign diff     = a - b_op;
    assign pc_plus4 = pc + 'd4;

    always_comb begin
        unique case (dec.alu_op)
            ALU_SUB: alu_res = diff;
            ALU_AND: alu_res = a & b_op;
            ALU_OR:  alu_res = a | b_op;
            ALU_XOR: alu_res = a ^ b_op;
            ALU_SLT: alu_res = {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b_op)};
            ALU_SLL: alu_res = b_op << dec.shamt;  // Shifts take rt
            ALU_SRL: alu_res = b_op >> dec.shamt;
            default: alu_res = sum;
        endcase
    end

    // Signed overflow: operands agree in sign, result does not
    always_comb begin
        unique case (dec.alu_op)
            ALU_ADD: ovf = (a[`CPU_XLEN-1] == b_op[`CPU_XLEN-1]) &&
                           (sum[`CPU_XLEN-1] != a[`CPU_XLEN-1]);
            ALU_SUB: ovf = (a[`CPU_XLEN-1] != b_op[`CPU_XLEN-1]) &&
                           (diff[`CPU_XLEN-1] != a[`CPU_XLEN-1]);
            default: ovf = 1'b0;
        endcase
    end
    assign overflow = ovf && dec.gp_we;

    assign eq           = (a == b);
    assign branch_taken = dec.jump | (dec.branch_eq & eq) | (dec.branch_ne & ~eq);
    assign target = dec.jump ?
        {pc_plus4[`CPU_XLEN-1:`CPU_XLEN-4], ir.i_fmt.rs, ir.i_fmt.rt, ir.i_fmt.imm, 2'b00} :
        pc_plus4 + {imm_sext[`CPU_XLEN-3:0], 2'b00};  // Word offset

    assign ea         = a + imm_sext;
    assign store_data = b;

    always_comb begin
        unique case (dec.sel_wb)
            WB_SPR:  result = spr_rdata;
            WB_MEM:  result = load_done ? mem_rdata : '0;
            default: result = alu_res;
        endcase
    end
endmodule

/* design/gpr_file.sv */
`include "cpu_defines.svh"

module gpr_file (
    input  logic                 E,
    input  logic                 jisr,
    input  logic [`CPU_RAW-1:0]  rs,
    input  logic [`CPU_RAW-1:0]  rt,
    input  logic [`CPU_RAW-1:0]  wa,
    input  logic [`CPU_XLEN-1:0] wd,
    input  logic                 we,
    output logic [`CPU_XLEN-1:0] rd1,
    output logic [`CPU_XLEN-1:0] rd2
);
    logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

    always_ff @(posedge E or posedge jisr) begin
        if (jisr) begin
            for (int i = 0; i < `CPU_NREG; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin  // r0 never written, stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[rs];
    assign rd2 = regs[rt];
endmodule

/* design/instr_decoder.sv */
module instr_decoder import cpu_pkg::*; (
    input  instr_t ir,
    cpu_dec_if.dec dec
);
    always_comb begin
        dec.alu_op    = ALU_ADD;
        dec.use_imm   = 1'b0;
        dec.shamt     = ir.r_fmt.shamt;
        dec.sel_wb    = WB_ALU;
        dec.gp_we     = 1'b0;
        dec.wa        = ir.r_fmt.rd;
        dec.mem_rd    = 1'b0;
        dec.mem_wr    = 1'b0;
        dec.branch_eq = 1'b0;
        dec.branch_ne = 1'b0;
        dec.jump      = 1'b0;
        dec.spr_wr    = 1'b0;
        dec.spr_rd    = 1'b0;
        dec.is_eret   = 1'b0;
        dec.illegal   = 1'b0;

        unique case (ir.i_fmt.opcode)
            SPECIAL: begin
                dec.gp_we = 1'b1;
                case (ir.r_fmt.funct)
                    FN_ADD:  dec.alu_op = ALU_ADD;
                    FN_SUB:  dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    default: dec.illegal = 1'b1;
                endcase
            end
            ADDI: begin
                dec.gp_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.wa      = ir.i_fmt.rt;
            end
            LW: begin
                dec.mem_rd = 1'b1;  // Writes rt later, on the load response
                dec.sel_wb = WB_MEM;
                dec.wa     = ir.i_fmt.rt;
            end
            SW:  dec.mem_wr    = 1'b1;
            BEQ: dec.branch_eq = 1'b1;
            BNE: dec.branch_ne = 1'b1;
            J:   dec.jump      = 1'b1;
            COP0: begin
                case (ir.r_fmt.rs)
                    C0_MOVS2G: begin
                        dec.spr_rd = 1'b1;
                        dec.sel_wb = WB_SPR;
                        dec.wa     = ir.r_fmt.rt;
                    end
                    C0_MOVG2S: dec.spr_wr  = 1'b1;
                    C0_ERET:   dec.is_eret = 1'b1;
                    default:   dec.illegal = 1'b1;
                endcase
                // Only epc, ecause and status exist
                if ((dec.spr_rd || dec.spr_wr) && ir.r_fmt.rd > 5'd2)
                    dec.illegal = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end
endmodule

/* design/spr_file.sv */
`include "cpu_defines.svh"

module spr_file import cpu_pkg::*; (
    input  logic                 E,
    input  logic                 jisr,
    input  logic [2:0]           sel,
    input  logic [`CPU_XLEN-1:0] wdata,
    input  logic                 wr,
    input  logic                 trap,
    input  cause_e               trap_cause,
    input  logic [`CPU_XLEN-1:0] trap_pc,
    output logic [`CPU_XLEN-1:0] rdata,
    output logic [`CPU_XLEN-1:0] epc
);
    cause_e               ecause;
    logic [`CPU_XLEN-1:0] status;  // Number of traps taken

    always_ff @(posedge E or posedge jisr) begin
        if (jisr) begin
            epc    <= '0;
            ecause <= NONE;
            status <= '0;
        end else if (trap) begin  // Wins over a movg2s in the same cycle
            epc    <= trap_pc;
            ecause <= trap_cause;
            status <= status + 'd1;
        end else if (wr) begin
            case (sel)
                3'd0:    epc    <= wdata;
                3'd1:    ecause <= cause_e'(wdata[1:0]);
                3'd2:    status <= wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (sel)
            3'd0:    rdata = epc;
            3'd1:    rdata = {{(`CPU_XLEN-2){1'b0}}, ecause};
            3'd2:    rdata = status;
            default: rdata = '0;
        endcase
    end
endmodule

/* project.f */
+incdir+design
design/cpu_pkg.sv
design/cpu_dec_if.sv
design/instr_decoder.sv
design/exec_unit.sv
design/gpr_file.sv
design/spr_file.sv
design/cpu_sequencer.sv
design/cpu_top.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

/* testbench/cpu_chk.sv */
module cpu_chk (
    input logic E,
    input logic jisr,
    input logic mem_req,
    input logic mem_we,
    input logic mem_rvalid
);
    logic outstanding;  // Request issued, response not yet seen

    always_ff @(posedge E or posedge jisr) begin
        if (jisr)
            outstanding <= 1'b0;
        else if (mem_req)
            outstanding <= 1'b1;
        else if (mem_rvalid)
            outstanding <= 1'b0;
    end

    // Single outstanding request on the memory port
    req_while_busy: assert property (@(posedge E) disable iff (jisr)
        mem_req |-> !outstanding)
        else $error("mem_req raised while a request is still outstanding");

    rvalid_unrequested: assert property (@(posedge E) disable iff (jisr)
        mem_rvalid |-> outstanding)
        else $error("mem_rvalid returned with no request outstanding");

    quiet_in_reset: assert property (@(posedge E) jisr |-> !mem_req && !mem_we)
        else $error("memory request driven while jisr is high");
endmodule

bind cpu_top cpu_chk chk0 (
    .E(E),
    .jisr(jisr),
    .mem_req(mem_req),
    .mem_we(mem_we),
    .mem_rvalid(mem_rvalid)
);

/* testbench/cpu_tb.sv */
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*; ();
    localparam int          MEM_WORDS     = 256;
    localparam int          RESET_AT_STEP = 20;  // Reset lands among the result stores
    localparam logic [31:0] MARKER        = 32'h0000_03fc;

    logic                 E;
    logic                 jisr;
    logic                 mem_req, mem_we, mem_rvalid;
    logic [`CPU_AW-1:0]   mem_addr;
    logic [`CPU_XLEN-1:0] mem_wdata, mem_rdata;

    logic [31:0] mem [MEM_WORDS];        // Memory behind the DUT port
    logic [31:0] model_mem [MEM_WORDS];  // Reference copy
    logic [31:0] m_reg [32];
    logic [31:0] m_pc, m_epc, m_status;
    cause_e      m_cause;

    logic [1:0]  acc_kind;  // 0 none, 1 load, 2 store
    logic [31:0] acc_addr, acc_data;
    logic        expect_data, pending, marker_seen;
    logic [7:0]  pend_idx;
    integer      seed;
    int          at, prog_len, steps, cycles, wait_cnt, err_count;

    cpu_top dut0 (
        .E(E), .jisr(jisr),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid)
    );

    initial begin
        E = 1'b0;
        forever #2 E = ~E;
    end

    function automatic logic [31:0] rtype(funct_e fn, int rd, int rs, int rt, int sh);
        return {SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] itype(opcode_e op, int rt, int rs, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] cop0(cop0_sel_e sel, int gr, int sr);
        return {COP0, sel, 5'(gr), 5'(sr), 11'd0};
    endfunction

    task automatic put(input logic [31:0] w);
        mem[at] = w;
        at++;
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = i * 32'h9e37_79b1;  // Background fill
        mem[144] = 32'h1357_9bdf;       // Load operand at 0x240
        at = 0;
        put(itype(ADDI, 1, 0, 16'h0200));   // r1 data base
        put(itype(ADDI, 22, 0, 16'h0280));  // r22 trap log pointer
        put(itype(ADDI, 2, 0, 16'h04d2));
        put(itype(ADDI, 3, 0, 16'hffb3));
        put(rtype(FN_ADD, 4, 2, 3, 0));
        put(rtype(FN_SUB, 5, 2, 3, 0));
        put(rtype(FN_AND, 6, 2, 3, 0));
        put(rtype(FN_OR, 7, 2, 3, 0));
        put(rtype(FN_XOR, 8, 2, 3, 0));
        put(rtype(FN_SLT, 9, 3, 2, 0));
        put(rtype(FN_SLL, 10, 0, 3, 4));
        put(rtype(FN_SRL, 11, 0, 3, 3));
        for (int k = 0; k < 8; k++)
            put(itype(SW, 4 + k, 1, 16'(4 * k)));
        put(itype(LW, 12, 1, 16'h0000));
        put(itype(LW, 13, 1, 16'h0040));
        put(rtype(FN_ADD, 14, 12, 13, 0));
        put(itype(SW, 14, 1, 16'h0020));
        put(itype(BEQ, 3, 2, 16'h0002));    // Not taken
        put(itype(BNE, 3, 2, 16'h0001));    // Taken
        put(itype(ADDI, 15, 0, 16'h0063));
        put(itype(BEQ, 4, 12, 16'h0001));   // Taken, loaded value equals r4
        put(itype(ADDI, 15, 0, 16'h0037));
        put(itype(BNE, 0, 0, 16'h0001));    // Not taken
        put({J, 26'd32});
        put(itype(ADDI, 15, 0, 16'h000b));
        put(itype(ADDI, 16, 0, 16'hffff));
        put(rtype(FN_SRL, 16, 0, 16, 1));   // r16 = largest positive
        put(itype(ADDI, 17, 0, 16'h0007));
        put(rtype(FN_ADD, 17, 16, 16, 0));  // Overflow trap
        put(itype(SW, 17, 1, 16'h0024));
        put(32'hfc00_0000);                 // Unknown opcode
        put(itype(ADDI, 18, 0, 16'h05a5));
        put(itype(SW, 18, 0, MARKER[15:0]));
        at = int'(`CPU_TRAP_VEC >> 2);
        put(cop0(C0_MOVS2G, 20, 0));
        put(cop0(C0_MOVS2G, 21, 1));
        put(cop0(C0_MOVS2G, 19, 2));         // Trap count
        put(itype(SW, 20, 22, 16'h0000));
        put(itype(SW, 21, 22, 16'h0004));
        put(itype(SW, 19, 22, 16'h0008));
        put(itype(ADDI, 22, 22, 16'h000c));
        put(itype(ADDI, 20, 20, 16'h0004));  // Resume past the faulting word
        put(cop0(C0_MOVG2S, 20, 0));
        put(cop0(C0_ERET, 0, 0));
    endtask

    task automatic model_reset();
        for (int i = 0; i < 32; i++)
            m_reg[i] = 32'd0;
        m_pc        = 32'd0;
        m_epc       = 32'd0;
        m_cause     = NONE;
        m_status    = 32'd0;
        expect_data = 1'b0;
    endtask

    // Runs the word at m_pc on the reference state, returns the next pc
    function automatic logic [31:0] model_step(output logic [1:0] kind,
                                               output logic [31:0] addr,
                                               output logic [31:0] data);
        logic [31:0] w, a, b, sx, res, nxt;
        logic [4:0]  rs, rt, rd;
        logic        ovf, bad;
        w    = model_mem[m_pc[9:2]];
        rs   = w[25:21];
        rt   = w[20:16];
        rd   = w[15:11];
        a    = m_reg[rs];
        b    = m_reg[rt];
        sx   = {{16{w[15]}}, w[15:0]};
        nxt  = m_pc + 32'd4;
        kind = 2'd0;
        addr = a + sx;
        data = b;
        res  = 32'd0;
        ovf  = 1'b0;
        bad  = 1'b0;
        case (w[31:26])
            SPECIAL: begin
                case (w[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    FN_SLL:  res = b << w[10:6];
                    FN_SRL:  res = b >> w[10:6];
                    default: bad = 1'b1;
                endcase
                if (w[5:0] == FN_ADD)
                    ovf = (a[31] == b[31]) && (res[31] != a[31]);
                if (w[5:0] == FN_SUB)
                    ovf = (a[31] != b[31]) && (res[31] != a[31]);
                if (!bad && !ovf && rd != 5'd0)
                    m_reg[rd] = res;
            end
            ADDI: begin
                res = a + sx;
                ovf = (a[31] == sx[31]) && (res[31] != a[31]);
                if (!ovf && rt != 5'd0)
                    m_reg[rt] = res;
            end
            LW: begin
                kind = 2'd1;
                if (rt != 5'd0)
                    m_reg[rt] = model_mem[addr[9:2]];
            end
            SW:  kind = 2'd2;
            BEQ: if (a == b) nxt = nxt + {sx[29:0], 2'b00};
            BNE: if (a != b) nxt = nxt + {sx[29:0], 2'b00};
            J:   nxt = {nxt[31:28], w[25:0], 2'b00};
            COP0: begin
                if ((rs == C0_MOVS2G || rs == C0_MOVG2S) && rd > 5'd2)
                    bad = 1'b1;  // Only epc, ecause, status
                else if (rs == C0_MOVS2G && rt != 5'd0)
                    m_reg[rt] = (rd == 5'd0) ? m_epc :
                                (rd == 5'd1) ? {30'd0, m_cause} : m_status;
                else if (rs == C0_MOVG2S) begin
                    if (rd == 5'd0)
                        m_epc = b;
                    else if (rd == 5'd1)
                        m_cause = cause_e'(b[1:0]);
                    else
                        m_status = b;
                end else if (rs == C0_ERET)
                    nxt = m_epc;
                else if (rs != C0_MOVS2G)
                    bad = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        if (bad || ovf) begin
            m_epc    = m_pc;
            m_cause  = bad ? ILLEGAL : OVERFLOW;
            m_status = m_status + 32'd1;
            kind     = 2'd0;
            nxt      = `CPU_TRAP_VEC;
        end
        return nxt;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Memory with 1 to 4 cycles of response delay
    always @(negedge E) begin
        mem_rvalid <= 1'b0;
        if (jisr) begin
            pending = 1'b0;
        end else begin
            if (pending) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= mem[pend_idx];
                    pending = 1'b0;
                end
            end
            if (mem_req) begin
                pend_idx = mem_addr[7:0];
                if (mem_we)
                    mem[pend_idx] = mem_wdata;
                wait_cnt = 1 + int'($unsigned($random(seed)) % 32'd4);
                pending = 1'b1;
            end
        end
    end

    // Every request against the reference
    always @(negedge E) begin
        if (jisr) begin
            model_reset();
        end else if (mem_req && !expect_data) begin
            check("mem_we on fetch", 32'(mem_we), 32'd0);
            check("fetch mem_addr (byte)", {mem_addr, 2'b00}, m_pc);
            m_pc = model_step(acc_kind, acc_addr, acc_data);
            steps++;
            expect_data = (acc_kind != 2'd0);
        end else if (mem_req) begin
            check("mem_we on data access", 32'(mem_we), 32'(acc_kind == 2'd2));
            check("data mem_addr (byte)", {mem_addr, 2'b00}, {acc_addr[31:2], 2'b00});
            if (acc_kind == 2'd2) begin
                check("mem_wdata", mem_wdata, acc_data);
                model_mem[acc_addr[9:2]] = acc_data;
                if (acc_addr == MARKER)
                    marker_seen = 1'b1;
            end
            expect_data = 1'b0;
        end
    end

    // Bound on run length, two passes over the program at most
    always @(posedge E) begin
        cycles++;
        if (cycles > 30 * 2 * prog_len) begin
            $display("Timeout: no store to the marker address after %0d cycles", cycles);
            $display("test failed");
            $fatal(1, "simulation timeout");
        end
    end

    initial begin
        seed        = 32'hb9ed;
        jisr        = 1'b1;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        pending     = 1'b0;
        marker_seen = 1'b0;
        expect_data = 1'b0;
        steps       = 0;
        cycles      = 0;
        err_count   = 0;
        prog_len    = 0;
        load_program();
        model_mem = mem;
        repeat (2) @(negedge E);
        jisr <= 1'b0;
        wait (steps == RESET_AT_STEP);
        @(negedge E);
        jisr <= 1'b1;  // Reset in the middle of the program
        repeat (2) @(negedge E);
        jisr <= 1'b0;
        wait (marker_seen);
        if (err_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "checks reported mismatches");
        end
    end
endmodule
